//--- design/trace_mon_macros.svh
`ifndef TRACE_MON_MACROS_SVH
`define TRACE_MON_MACROS_SVH

// Number of cores that share the execution trace bus
`define TM_NUM_CORES 4

// Register file and writeback data width
`define TM_XLEN 32

// Bits needed to carry a core number on the trace bus
`define TM_CORE_BITS $clog2(`TM_NUM_CORES)

`endif

//--- design/trace_mon_pkg.sv
`include "trace_mon_macros.svh"

package trace_mon_pkg;

  // Core number as tagged on each trace beat
  typedef logic [`TM_CORE_BITS-1:0] core_id_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // Data or instruction word
  typedef logic [`TM_XLEN-1:0] word_t;

  // Immediate of "addi x0, x0, K" selects the simulation operation
  typedef enum logic [11:0] {
    SIM_EXIT = 12'd1,
    SIM_PUTC = 12'd4
  } sim_op_e;

  // addi x0, x0, 0 with the immediate field in bits 31..20 left at zero
  localparam word_t SIM_OP_BASE = 32'h0000_0013;

  // x3 carries the argument of both simulation operations
  localparam reg_idx_t SHADOW_REG = 5'd3;

endpackage

//--- design/trace_router.sv
`timescale 1ns/1ps
`include "trace_mon_macros.svh"

module trace_router #(
  parameter int unsigned NUM_CORES = `TM_NUM_CORES
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     trace_valid_i,
  input  trace_mon_pkg::core_id_t  trace_core_i,
  input  trace_mon_pkg::word_t     trace_insn_i,
  input  logic                     trace_wb_en_i,
  input  trace_mon_pkg::reg_idx_t  trace_wb_reg_i,
  input  trace_mon_pkg::word_t     trace_wb_data_i,
  output logic [NUM_CORES-1:0]     lane_valid_o,
  output trace_mon_pkg::word_t     lane_insn_o,
  output logic                     lane_wb_en_o,
  output trace_mon_pkg::reg_idx_t  lane_wb_reg_o,
  output trace_mon_pkg::word_t     lane_wb_data_o
);

  import trace_mon_pkg::*;

  logic [NUM_CORES-1:0] lane_sel;

  // One-hot steering by the core tag of the incoming beat
  always_comb begin
    for (int unsigned n = 0; n < NUM_CORES; n++) begin
      lane_sel[n] = trace_valid_i && (trace_core_i == core_id_t'(n));
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lane_valid_o <= '0;
    end else begin
      lane_valid_o <= lane_sel;
    end
  end

  // Payload is shared by all lanes, only the valid bit is per lane
  always_ff @(posedge clk) begin
    if (trace_valid_i) begin
      lane_insn_o    <= trace_insn_i;
      lane_wb_en_o   <= trace_wb_en_i;
      lane_wb_reg_o  <= trace_wb_reg_i;
      lane_wb_data_o <= trace_wb_data_i;
    end
  end

  // Every accepted beat reaches exactly one lane on the next cycle
  a_beat_to_one_lane: assert property (@(posedge clk) disable iff (rst_i)
    trace_valid_i |=> $onehot(lane_valid_o));

endmodule

//--- design/core_trace_monitor.sv
`timescale 1ns/1ps

module core_trace_monitor (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     lane_valid_i,
  input  trace_mon_pkg::word_t     lane_insn_i,
  input  logic                     lane_wb_en_i,
  input  trace_mon_pkg::reg_idx_t  lane_wb_reg_i,
  input  trace_mon_pkg::word_t     lane_wb_data_i,
  input  logic                     putc_grant_i,
  output logic                     putc_pend_o,
  output logic [7:0]               putc_char_o,
  output logic                     exit_pulse_o,
  output trace_mon_pkg::word_t     exit_code_o,
  output logic                     overflow_o
);

  import trace_mon_pkg::*;

  // Full instruction words of the two simulation operations
  localparam word_t PUTC_INSN = SIM_OP_BASE | word_t'({SIM_PUTC, 20'h00000});
  localparam word_t EXIT_INSN = SIM_OP_BASE | word_t'({SIM_EXIT, 20'h00000});

  word_t shadow_x3;
  logic  exited;
  logic  beat_live;
  logic  is_putc;
  logic  is_exit;
  logic  x3_write;

  // Beats after an exit are dropped entirely
  assign beat_live = lane_valid_i && !exited;
  assign is_putc   = beat_live && (lane_insn_i == PUTC_INSN);
  assign is_exit   = beat_live && (lane_insn_i == EXIT_INSN);
  assign x3_write  = beat_live && lane_wb_en_i && (lane_wb_reg_i == SHADOW_REG);

  // Shadow of x3, updated from writebacks seen on the trace
  always_ff @(posedge clk) begin
    if (rst_i) begin
      shadow_x3 <= '0;
    end else if (x3_write) begin
      shadow_x3 <= lane_wb_data_i;
    end
  end

  // Pending character; a grant in this cycle has already taken the old byte
  always_ff @(posedge clk) begin
    if (rst_i) begin
      putc_pend_o <= 1'b0;
      overflow_o  <= 1'b0;
    end else if (is_putc) begin
      putc_pend_o <= 1'b1;
      if (putc_pend_o && !putc_grant_i) begin
        overflow_o <= 1'b1;
      end
    end else if (putc_grant_i) begin
      putc_pend_o <= 1'b0;
    end
  end

  // Decode reads x3 as it was before this beat
  always_ff @(posedge clk) begin
    if (is_putc) begin
      putc_char_o <= shadow_x3[7:0];
    end
    if (is_exit) begin
      exit_code_o <= shadow_x3;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      exit_pulse_o <= 1'b0;
      exited       <= 1'b0;
    end else begin
      exit_pulse_o <= is_exit;
      if (is_exit) begin
        exited <= 1'b1;
      end
    end
  end

  // A core reports its exit once per run
  a_single_exit: assert property (@(posedge clk) disable iff (rst_i)
    exit_pulse_o |=> always !exit_pulse_o);

endmodule

//--- design/stdout_arbiter.sv
`timescale 1ns/1ps
`include "trace_mon_macros.svh"

module stdout_arbiter #(
  parameter int unsigned NUM_CORES = `TM_NUM_CORES
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic [NUM_CORES-1:0]     putc_pend_i,
  input  logic [7:0]               putc_char_i [NUM_CORES],
  output logic [NUM_CORES-1:0]     putc_grant_o,
  output logic                     char_valid_o,
  output trace_mon_pkg::core_id_t  char_core_o,
  output logic [7:0]               char_data_o
);

  import trace_mon_pkg::*;

  logic [NUM_CORES-1:0] req;
  logic                 found;
  core_id_t             sel;
  core_id_t             rr_ptr;

  // A lane whose grant is out this cycle still shows pend, skip it
  assign req = putc_pend_i & ~putc_grant_o;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NUM_CORES; i++) begin
      idx = (rr_ptr + i) % NUM_CORES;
      if (!found && req[idx]) begin
        found = 1'b1;
        sel   = core_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rr_ptr       <= '0;
      putc_grant_o <= '0;
      char_valid_o <= 1'b0;
    end else begin
      putc_grant_o <= '0;
      char_valid_o <= found;
      if (found) begin
        putc_grant_o[sel] <= 1'b1;
        // Winner goes to the back of the queue
        rr_ptr <= (sel == core_id_t'(NUM_CORES - 1)) ? '0 : core_id_t'(sel + 1'b1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      char_core_o <= sel;
      char_data_o <= putc_char_i[sel];
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(putc_grant_o));
  // Lanes keep pend up until the grant has been seen
  a_grant_to_pending: assert property (@(posedge clk) disable iff (rst_i)
    (putc_grant_o & ~putc_pend_i) == '0);

endmodule

//--- design/termination_tracker.sv
`timescale 1ns/1ps
`include "trace_mon_macros.svh"

module termination_tracker #(
  parameter int unsigned NUM_CORES = `TM_NUM_CORES
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic [NUM_CORES-1:0]  exit_pulse_i,
  input  trace_mon_pkg::word_t  exit_code_i [NUM_CORES],
  output logic [NUM_CORES-1:0]  core_done_o,
  output logic                  all_done_o,
  output logic                  fail_o
);

  logic [NUM_CORES-1:0] bad_exit;

  // Nonzero exit code on any exiting core counts as a failure
  always_comb begin
    for (int unsigned n = 0; n < NUM_CORES; n++) begin
      bad_exit[n] = exit_pulse_i[n] && (exit_code_i[n] != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      core_done_o <= '0;
      all_done_o  <= 1'b0;
      fail_o      <= 1'b0;
    end else begin
      core_done_o <= core_done_o | exit_pulse_i;
      // Follows the done mask by one cycle
      all_done_o  <= &core_done_o;
      if (|bad_exit) begin
        fail_o <= 1'b1;
      end
    end
  end

endmodule

//--- design/trace_mon_top.sv
`timescale 1ns/1ps
`include "trace_mon_macros.svh"

module trace_mon_top #(
  parameter int unsigned NUM_CORES = `TM_NUM_CORES
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     trace_valid_i,
  input  trace_mon_pkg::core_id_t  trace_core_i,
  input  trace_mon_pkg::word_t     trace_insn_i,
  input  logic                     trace_wb_en_i,
  input  trace_mon_pkg::reg_idx_t  trace_wb_reg_i,
  input  trace_mon_pkg::word_t     trace_wb_data_i,
  output logic                     char_valid_o,
  output trace_mon_pkg::core_id_t  char_core_o,
  output logic [7:0]               char_data_o,
  output logic [NUM_CORES-1:0]     core_done_o,
  output logic                     all_done_o,
  output logic                     fail_o,
  output logic                     overflow_o
);

  import trace_mon_pkg::*;

  logic [NUM_CORES-1:0] lane_valid;
  word_t                lane_insn;
  logic                 lane_wb_en;
  reg_idx_t             lane_wb_reg;
  word_t                lane_wb_data;

  logic [NUM_CORES-1:0] putc_pend;
  logic [7:0]           putc_char [NUM_CORES];
  logic [NUM_CORES-1:0] putc_grant;
  logic [NUM_CORES-1:0] exit_pulse;
  word_t                exit_code [NUM_CORES];
  logic [NUM_CORES-1:0] lane_overflow;

  trace_router #(
    .NUM_CORES (NUM_CORES)
  ) u_router (
    .clk             (clk),
    .rst_i           (rst_i),
    .trace_valid_i   (trace_valid_i),
    .trace_core_i    (trace_core_i),
    .trace_insn_i    (trace_insn_i),
    .trace_wb_en_i   (trace_wb_en_i),
    .trace_wb_reg_i  (trace_wb_reg_i),
    .trace_wb_data_i (trace_wb_data_i),
    .lane_valid_o    (lane_valid),
    .lane_insn_o     (lane_insn),
    .lane_wb_en_o    (lane_wb_en),
    .lane_wb_reg_o   (lane_wb_reg),
    .lane_wb_data_o  (lane_wb_data)
  );

  // One monitor per core, all fed from the shared lane payload
  for (genvar n = 0; n < NUM_CORES; n++) begin : gen_lane
    core_trace_monitor u_mon (
      .clk            (clk),
      .rst_i          (rst_i),
      .lane_valid_i   (lane_valid[n]),
      .lane_insn_i    (lane_insn),
      .lane_wb_en_i   (lane_wb_en),
      .lane_wb_reg_i  (lane_wb_reg),
      .lane_wb_data_i (lane_wb_data),
      .putc_grant_i   (putc_grant[n]),
      .putc_pend_o    (putc_pend[n]),
      .putc_char_o    (putc_char[n]),
      .exit_pulse_o   (exit_pulse[n]),
      .exit_code_o    (exit_code[n]),
      .overflow_o     (lane_overflow[n])
    );
  end

  stdout_arbiter #(
    .NUM_CORES (NUM_CORES)
  ) u_arbiter (
    .clk          (clk),
    .rst_i        (rst_i),
    .putc_pend_i  (putc_pend),
    .putc_char_i  (putc_char),
    .putc_grant_o (putc_grant),
    .char_valid_o (char_valid_o),
    .char_core_o  (char_core_o),
    .char_data_o  (char_data_o)
  );

  termination_tracker #(
    .NUM_CORES (NUM_CORES)
  ) u_tracker (
    .clk          (clk),
    .rst_i        (rst_i),
    .exit_pulse_i (exit_pulse),
    .exit_code_i  (exit_code),
    .core_done_o  (core_done_o),
    .all_done_o   (all_done_o),
    .fail_o       (fail_o)
  );

  assign overflow_o = |lane_overflow;

endmodule

//--- verification/tb_trace_mon.sv
`timescale 1ns/1ps
`include "trace_mon_macros.svh"

module tb_trace_mon;

  import trace_mon_pkg::*;

  localparam int NC = `TM_NUM_CORES;
  localparam int TIMEOUT_CYCLES = 200;
  // addi x0, x0, K with K in bits 31..20
  localparam logic [31:0] INSN_EXIT = 32'h0010_0013;

  typedef struct packed {
    logic [7:0]  core;
    logic [31:0] insn;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic [7:0]  idle;
  } beat_t;

  logic            clk;
  logic            rst_i;
  logic            trace_valid_i;
  core_id_t        trace_core_i;
  word_t           trace_insn_i;
  logic            trace_wb_en_i;
  reg_idx_t        trace_wb_reg_i;
  word_t           trace_wb_data_i;
  logic            char_valid_o;
  core_id_t        char_core_o;
  logic [7:0]      char_data_o;
  logic [NC-1:0]   core_done_o;
  logic            all_done_o;
  logic            fail_o;
  logic            overflow_o;

  beat_t           beats [$];
  // Expected characters as {core, byte}, in order within each core
  logic [15:0]     exp_chars [$];
  logic [NC-1:0]   exits_sent;
  logic [31:0]     exp_done;
  logic [31:0]     exp_fail;

  trace_mon_top dut (
    .clk             (clk),
    .rst_i           (rst_i),
    .trace_valid_i   (trace_valid_i),
    .trace_core_i    (trace_core_i),
    .trace_insn_i    (trace_insn_i),
    .trace_wb_en_i   (trace_wb_en_i),
    .trace_wb_reg_i  (trace_wb_reg_i),
    .trace_wb_data_i (trace_wb_data_i),
    .char_valid_o    (char_valid_o),
    .char_core_o     (char_core_o),
    .char_data_o     (char_data_o),
    .core_done_o     (core_done_o),
    .all_done_o      (all_done_o),
    .fail_o          (fail_o),
    .overflow_o      (overflow_o)
  );

  always #4 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      stop_with_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic load_testdata();
    int               fd;
    int               code;
    logic [63:0]      kind;
    logic [8*128-1:0] rest;
    beat_t            b;
    logic [31:0]      v_core;
    logic [31:0]      v_insn;
    logic [31:0]      v_en;
    logic [31:0]      v_reg;
    logic [31:0]      v_data;
    logic [31:0]      v_idle;
    fd = $fopen("verification/trace_mon_testdata.txt", "r");
    assert (fd != 0) else
      stop_with_failure("Could not open verification/trace_mon_testdata.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "B") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", v_core, v_insn, v_en, v_reg, v_data, v_idle);
        assert (code == 6) else stop_with_failure("Malformed beat record in test data");
        b.core    = v_core[7:0];
        b.insn    = v_insn;
        b.wb_en   = v_en[0];
        b.wb_reg  = v_reg[4:0];
        b.wb_data = v_data;
        b.idle    = v_idle[7:0];
        beats.push_back(b);
      end else if (kind == "S") begin
        code = $fscanf(fd, "%h %h", v_core, v_idle);
        for (int i = 0; i < int'(v_idle); i++) begin
          code = $fscanf(fd, "%h", v_data);
          exp_chars.push_back({v_core[7:0], v_data[7:0]});
        end
      end else if (kind == "F") begin
        code = $fscanf(fd, "%h %h", exp_done, exp_fail);
      end else begin
        stop_with_failure($sformatf("Unknown record kind %s in test data", kind));
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_beat(input beat_t b);
    @(posedge clk);
    trace_valid_i   <= 1'b1;
    trace_core_i    <= core_id_t'(b.core);
    trace_insn_i    <= b.insn;
    trace_wb_en_i   <= b.wb_en;
    trace_wb_reg_i  <= b.wb_reg;
    trace_wb_data_i <= b.wb_data;
    if (b.insn == INSN_EXIT) begin
      exits_sent[b.core] = 1'b1;
    end
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      trace_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_core_done(input int core);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!core_done_o[core] && cycles < TIMEOUT_CYCLES);
    assert (core_done_o[core]) else
      stop_with_failure($sformatf("Timeout: core_done_o never set for core %0d", core));
  endtask

  task automatic wait_all_done();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!all_done_o && cycles < TIMEOUT_CYCLES);
    assert (all_done_o) else stop_with_failure("Timeout: all_done_o never rose");
  endtask

  task automatic wait_chars_drained();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (exp_chars.size() != 0 && cycles < TIMEOUT_CYCLES);
    assert (exp_chars.size() == 0) else
      stop_with_failure($sformatf("Timeout: %0d expected characters never came",
                                  exp_chars.size()));
  endtask

  // Match against the oldest expected byte of the same core
  task automatic take_char(input core_id_t core, input logic [7:0] data);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_chars.size(); i++) begin
      if (idx < 0 && exp_chars[i][15:8] == 8'(core)) begin
        idx = i;
      end
    end
    assert (idx >= 0) else
      stop_with_failure($sformatf("Core %0d printed 0x%h but no character was expected",
                                  core, data));
    check_value("char_data_o", data, exp_chars[idx][7:0]);
    exp_chars.delete(idx);
  endtask

  always @(negedge clk) begin
    if (!rst_i) begin
      if (char_valid_o) begin
        take_char(char_core_o, char_data_o);
      end
      assert ((core_done_o & ~exits_sent) == '0) else
        stop_with_failure($sformatf("CHECK FAILED core_done_o 0x%h set before exit, exits 0x%h",
                                    core_done_o, exits_sent));
      assert (!all_done_o || (&exits_sent)) else
        stop_with_failure("all_done_o rose before every core had exited");
      check_value("overflow_o", overflow_o, 32'h0);
    end
  end

  initial begin
    clk             = 1'b0;
    rst_i           = 1'b1;
    trace_valid_i   = 1'b0;
    trace_core_i    = '0;
    trace_insn_i    = '0;
    trace_wb_en_i   = 1'b0;
    trace_wb_reg_i  = '0;
    trace_wb_data_i = '0;
    exits_sent      = '0;
    void'($urandom(32'h556e_a495));
    load_testdata();
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    // Outputs come out of reset idle
    @(negedge clk);
    check_value("char_valid_o", char_valid_o, 32'h0);
    check_value("core_done_o", core_done_o, 32'h0);
    check_value("all_done_o", all_done_o, 32'h0);
    check_value("fail_o", fail_o, 32'h0);
    foreach (beats[i]) begin
      drive_beat(beats[i]);
      if (beats[i].insn == INSN_EXIT) begin
        drive_idle(1);
        wait_core_done(int'(beats[i].core));
      end
      // Zero idle keeps a burst back to back
      if (beats[i].idle != 0) begin
        drive_idle(int'(beats[i].idle) + int'($urandom_range(3)));
      end
    end
    drive_idle(1);
    wait_all_done();
    wait_chars_drained();
    check_value("core_done_o", core_done_o, exp_done);
    check_value("fail_o", fail_o, exp_fail);
    check_value("overflow_o", overflow_o, 32'h0);
    $display("Test OK");
    $finish;
  end

endmodule

//--- verification/trace_mon_testdata.txt
# B core insn wb_en wb_reg wb_data idle : one trace beat, then idle cycles (hex)
# S core count bytes : expected characters of a core ; F done_mask fail : final flags
B 0 04800193 1 03 00000048 2
B 0 00400013 0 00 00000000 2
B 0 05a00293 1 05 0000005a 2
B 0 00400013 0 00 00000000 2
B 0 06900193 1 03 00000069 0
B 1 04100193 1 03 00000041 0
B 2 04200193 1 03 00000042 0
B 3 04300193 1 03 00000043 0
B 0 00400013 0 00 00000000 0
B 1 00400013 0 00 00000000 0
B 2 00400013 0 00 00000000 0
B 3 00400013 0 00 00000000 0
B 0 02100193 1 03 00000021 0
B 1 06200193 1 03 00000062 0
B 2 06300193 1 03 00000063 0
B 3 06400193 1 03 00000064 0
B 0 00400013 0 00 00000000 0
B 1 00400013 0 00 00000000 0
B 2 00400013 0 00 00000000 0
B 3 00400013 0 00 00000000 3
B 1 00000193 1 03 00000000 1
B 1 00100013 0 00 00000000 1
B 2 00000193 1 03 00000000 1
B 2 00100013 0 00 00000000 1
B 2 05800193 1 03 00000058 1
B 2 00400013 0 00 00000000 1
B 3 00100013 0 00 00000000 1
B 0 00000193 1 03 00000000 1
B 0 00100013 0 00 00000000 1
S 0 4 48 48 69 21
S 1 2 41 62
S 2 2 42 63
S 3 2 43 64
F f 1

//--- tb.f
+incdir+design
design/trace_mon_pkg.sv
design/trace_router.sv
design/core_trace_monitor.sv
design/stdout_arbiter.sv
design/termination_tracker.sv
design/trace_mon_top.sv
verification/tb_trace_mon.sv

//--- Bender.yml
package:
  name: trace_mon

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/trace_mon_pkg.sv
      - design/trace_router.sv
      - design/core_trace_monitor.sv
      - design/stdout_arbiter.sv
      - design/termination_tracker.sv
      - design/trace_mon_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_trace_mon.sv
